// ==== verilog/piano_params.svh ====
// Width defines for state codes, mode word, error choices and menu select
`ifndef PIANO_PARAMS_SVH
`define PIANO_PARAMS_SVH

// --------------------------------------------------
// State encoding
// --------------------------------------------------

// Shared by both state machines and the debug output
`define PIANO_STATE_W 6

// --------------------------------------------------
// Player inputs and menu outputs
// --------------------------------------------------

// One-hot mode word, freestyle and genius
`define PIANO_MODE_W 2

// Retry round, retry note, replay last
`define PIANO_ERROR_W 3

// Menu screen selector
`define PIANO_MENU_SEL_W 3

`endif

// ==== verilog/piano_pkg.sv ====
// Package with menu and round state enums, mode word and error choice types
`default_nettype none

`include "piano_params.svh"

package piano_pkg;

    // Setup menu states
    typedef enum logic [`PIANO_STATE_W-1:0] {
        menu_idle   = 6'h00,
        menu_open   = 6'h1C,
        wait_mode   = 6'h1D,
        wait_tempo  = 6'h1E,
        wait_key    = 6'h1F,
        wait_song   = 6'h20,
        menu_launch = 6'h30,
        menu_handed = 6'h31
    } menu_state_t;

    // Game states, genius and freestyle share one register
    typedef enum logic [`PIANO_STATE_W-1:0] {
        round_idle      = 6'h3F,
        init_elements   = 6'h01,
        round_start     = 6'h02,
        show            = 6'h03,
        show_wait       = 6'h04,
        show_next       = 6'h05,
        note_start      = 6'h06,
        note_wait       = 6'h07,
        compare         = 6'h09,
        won             = 6'h0A,
        next_note       = 6'h0B,
        advance_step    = 6'h13,
        note_wrong      = 6'h14,
        timing_wrong    = 6'h15,
        note_play       = 6'h17,
        show_last       = 6'h18,
        next_round      = 6'h19,
        check_end       = 6'h1A,
        store           = 6'h1B,
        error_menu_open = 6'h21,
        error_menu      = 6'h22,
        free_wait       = 6'h23,
        free_play       = 6'h2D
    } round_state_t;

    // One-hot mode word
    typedef struct packed {
        logic freestyle;
        logic genius;
    } mode_t;

    // Error menu choice, highest priority first
    typedef struct packed {
        logic retry_round;
        logic retry_note;
        logic replay_last;
    } error_choice_t;

endpackage

`default_nettype wire

// ==== verilog/status_if.sv ====
// Interface bundling the datapath condition levels with source and sink modports
`default_nettype none

interface status_if;

    logic lead_done;
    logic step_done;
    logic note_made;
    logic note_right;
    logic timing_right;
    logic timing_low;
    logic at_round_end;
    logic timer_expired;
    logic song_end;

    // Datapath side
    modport source (
        output lead_done, step_done, note_made, note_right, timing_right,
               timing_low, at_round_end, timer_expired, song_end
    );

    // Controller side
    modport sink (
        input lead_done, step_done, note_made, note_right, timing_right,
              timing_low, at_round_end, timer_expired, song_end
    );

endinterface

`default_nettype wire

// ==== verilog/menu_sequencer.sv ====
// Setup menu state machine with the mode register and the launch level
`default_nettype none

module menu_sequencer
    import piano_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  logic        enter,
    input  mode_t       mode,
    output logic        launch,
    output mode_t       mode_sel,
    output menu_state_t menu_state
);

    menu_state_t next_state;

    // --------------------------------------------------
    // State and mode registers
    // --------------------------------------------------

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            menu_state <= menu_idle;
        end else begin
            menu_state <= next_state;
        end
    end

    // Mode is taken when the player confirms the mode screen
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mode_sel <= '0;
        end else if (menu_state == wait_mode && enter) begin
            mode_sel <= mode;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------

    always_comb begin
        next_state = menu_state;
        case (menu_state)
            menu_idle:   next_state = start ? menu_open : menu_idle;
            menu_open:   next_state = wait_mode;
            wait_mode:   next_state = enter ? wait_tempo : wait_mode;
            wait_tempo:  next_state = enter ? wait_key : wait_tempo;
            wait_key: begin
                // Song choice only matters for genius
                if (enter) begin
                    next_state = mode_sel.genius ? wait_song : menu_launch;
                end
            end
            wait_song:   next_state = enter ? menu_launch : wait_song;
            menu_launch: next_state = menu_handed;
            menu_handed: next_state = menu_handed;
            default:     next_state = menu_idle;
        endcase
    end

    // High for the single hand-over cycle
    assign launch = (menu_state == menu_launch);

endmodule

`default_nettype wire

// ==== verilog/round_sequencer.sv ====
// Genius and freestyle game state machine including the error menu
`default_nettype none

module round_sequencer
    import piano_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          start,
    input  logic          enter,
    input  logic          launch,
    input  mode_t         mode_sel,
    input  error_choice_t error_choice,
    status_if.sink        status,
    output round_state_t  round_state
);

    round_state_t next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            round_state <= round_idle;
        end else begin
            round_state <= next_state;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------

    always_comb begin
        next_state = round_state;
        if (round_state == round_idle) begin
            next_state = launch ? init_elements : round_idle;
        end else if (mode_sel.genius) begin
            case (round_state)
                init_elements: next_state = round_start;
                round_start:   next_state = status.lead_done ? show : round_start;
                show:          next_state = show_wait;
                show_wait: begin
                    // Last shown element hands over to the player
                    if (status.timing_low) begin
                        next_state = status.at_round_end ? note_start : show_next;
                    end
                end
                show_next:     next_state = show;
                note_start:    next_state = note_wait;
                note_wait: begin
                    if (status.timer_expired) begin
                        next_state = timing_wrong;
                    end else if (status.note_made) begin
                        next_state = note_play;
                    end
                end
                note_play:     next_state = status.note_made ? note_play : compare;
                compare: begin
                    if (!status.note_right) begin
                        next_state = note_wrong;
                    end else if (!status.timing_right) begin
                        next_state = timing_wrong;
                    end else if (status.at_round_end) begin
                        next_state = status.step_done ? won : advance_step;
                    end else begin
                        next_state = next_note;
                    end
                end
                next_note:     next_state = note_wait;
                advance_step:  next_state = store;
                store:         next_state = check_end;
                check_end:     next_state = status.song_end ? won : next_round;
                next_round:    next_state = round_start;
                won:           next_state = start ? init_elements : won;
                note_wrong,
                timing_wrong:  next_state = error_menu_open;
                error_menu_open: next_state = error_menu;
                error_menu: begin
                    // No choice bit keeps the menu up
                    if (enter) begin
                        if (error_choice.retry_round) begin
                            next_state = round_start;
                        end else if (error_choice.retry_note) begin
                            next_state = note_start;
                        end else if (error_choice.replay_last) begin
                            next_state = show_last;
                        end
                    end
                end
                show_last:     next_state = status.timing_low ? note_wait : show_last;
                default:       next_state = round_idle;
            endcase
        end else begin
            // Freestyle
            case (round_state)
                init_elements: next_state = free_wait;
                free_wait:     next_state = status.note_made ? free_play : free_wait;
                free_play:     next_state = status.note_made ? free_play : free_wait;
                default:       next_state = free_wait;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/control_decoder.sv ====
// Moore output decoder for datapath strobes, indicators, menu select and debug code
`default_nettype none

`include "piano_params.svh"

module control_decoder
    import piano_pkg::*;
(
    input  menu_state_t                  menu_state,
    input  round_state_t                 round_state,
    output logic                         clear_note,
    output logic                         store_note,
    output logic                         clear_step,
    output logic                         count_step,
    output logic                         clear_note_count,
    output logic                         count_note_count,
    output logic                         clear_lead,
    output logic                         count_lead,
    output logic                         clear_timer,
    output logic                         count_timer,
    output logic                         player_turn,
    output logic                         clear_beat,
    output logic                         count_beat,
    output logic                         leds_from_memory,
    output logic                         leds_on,
    output logic                         sound,
    output logic                         won,
    output logic                         lost,
    output logic                         capture_error,
    output logic                         menu_open,
    output logic                         capture_tempo,
    output logic                         capture_key,
    output logic                         capture_song,
    output logic                         menu_visible,
    output logic [`PIANO_MENU_SEL_W-1:0] menu_sel,
    output logic [`PIANO_STATE_W-1:0]    db_state
);

    // --------------------------------------------------
    // Datapath strobes
    // --------------------------------------------------

    assign clear_note       = (menu_state == menu_idle) && (round_state == round_idle);
    assign store_note       = round_state inside {note_play, free_play};
    assign clear_step       = (round_state == init_elements);
    assign count_step       = (round_state == next_round);
    assign clear_note_count = round_state inside {note_start, round_start};
    assign count_note_count = round_state inside {advance_step, show_next, next_note};
    assign clear_lead       = round_state inside {show, init_elements, note_start};
    assign count_lead       = (round_state == round_start);

    assign clear_timer = round_state inside {next_note, note_start, init_elements,
                                             note_wrong, timing_wrong, check_end};
    assign count_timer = (round_state == note_wait);

    // Metronome
    assign clear_beat = round_state inside {show, note_wrong, timing_wrong, note_wait,
                                            init_elements, check_end};
    assign count_beat = round_state inside {show_last, show_wait, note_play,
                                            free_wait, free_play};

    assign capture_error = (round_state == compare);

    // --------------------------------------------------
    // Player indicators
    // --------------------------------------------------

    assign player_turn      = (round_state == note_wait);
    assign leds_from_memory = round_state inside {show_wait, show_last};
    assign leds_on          = round_state inside {note_play, free_play, show_wait, show_last};
    assign sound            = round_state inside {note_play, free_play};
    assign won              = (round_state == piano_pkg::won);
    assign lost             = round_state inside {note_wrong, timing_wrong};

    // --------------------------------------------------
    // Menu outputs
    // --------------------------------------------------

    assign menu_open     = (menu_state == piano_pkg::menu_open) ||
                           (round_state == error_menu_open);
    assign capture_tempo = (menu_state == wait_tempo);
    assign capture_key   = (menu_state == wait_key);
    assign capture_song  = (menu_state == wait_song);

    assign menu_visible = (menu_state inside {wait_mode, wait_tempo, wait_key, wait_song}) ||
                          (round_state == error_menu);

    // Screen code, setup screens in bits 1..0 and error screen in bit 2
    assign menu_sel[0] = menu_state inside {wait_tempo, wait_song};
    assign menu_sel[1] = menu_state inside {wait_key, wait_song};
    assign menu_sel[2] = (round_state == error_menu);

    // Menu code until hand-over, game code after
    assign db_state = (menu_state == menu_handed) ? round_state : menu_state;

endmodule

`default_nettype wire

// ==== verilog/piano_controller.sv ====
// Piano game controller top level with the menu, round and decoder instances
`default_nettype none

`include "piano_params.svh"

module piano_controller
    import piano_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         enter,
    input  logic [`PIANO_MODE_W-1:0]     mode,
    input  logic [`PIANO_ERROR_W-1:0]    error_choice,
    input  logic                         lead_done,
    input  logic                         step_done,
    input  logic                         note_made,
    input  logic                         note_right,
    input  logic                         timing_right,
    input  logic                         timing_low,
    input  logic                         at_round_end,
    input  logic                         timer_expired,
    input  logic                         song_end,
    output logic                         clear_note,
    output logic                         store_note,
    output logic                         clear_step,
    output logic                         count_step,
    output logic                         clear_note_count,
    output logic                         count_note_count,
    output logic                         clear_lead,
    output logic                         count_lead,
    output logic                         clear_timer,
    output logic                         count_timer,
    output logic                         player_turn,
    output logic                         clear_beat,
    output logic                         count_beat,
    output logic                         leds_from_memory,
    output logic                         leds_on,
    output logic                         sound,
    output logic                         won,
    output logic                         lost,
    output logic                         capture_error,
    output logic                         menu_open,
    output logic                         capture_tempo,
    output logic                         capture_key,
    output logic                         capture_song,
    output logic                         menu_visible,
    output logic [`PIANO_MENU_SEL_W-1:0] menu_sel,
    output logic [`PIANO_STATE_W-1:0]    db_state
);

    logic         launch;
    mode_t        mode_sel;
    menu_state_t  menu_state;
    round_state_t round_state;

    // --------------------------------------------------
    // Datapath condition levels
    // --------------------------------------------------

    status_if status ();

    assign status.lead_done     = lead_done;
    assign status.step_done     = step_done;
    assign status.note_made     = note_made;
    assign status.note_right    = note_right;
    assign status.timing_right  = timing_right;
    assign status.timing_low    = timing_low;
    assign status.at_round_end  = at_round_end;
    assign status.timer_expired = timer_expired;
    assign status.song_end      = song_end;

    // --------------------------------------------------
    // Instances
    // --------------------------------------------------

    menu_sequencer u_menu (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .enter      (enter),
        .mode       (mode_t'(mode)),
        .launch     (launch),
        .mode_sel   (mode_sel),
        .menu_state (menu_state)
    );

    round_sequencer u_round (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .enter        (enter),
        .launch       (launch),
        .mode_sel     (mode_sel),
        .error_choice (error_choice_t'(error_choice)),
        .status       (status.sink),
        .round_state  (round_state)
    );

    // Port names match the top level one to one
    control_decoder u_decoder (.*);

endmodule

`default_nettype wire

// ==== bench/piano_controller_props.sv ====
// Concurrent assertions on the controller top-level ports
`default_nettype none

`include "piano_params.svh"

module piano_controller_props (
    input logic clock, reset, start,
    input logic store_note, clear_step, count_step, clear_note_count, count_note_count,
                clear_lead, count_lead, clear_timer, count_timer, player_turn, clear_beat,
                count_beat, leds_from_memory, leds_on, sound, won, lost, capture_error,
                menu_open, capture_tempo, capture_key, capture_song, menu_visible,
    input logic [`PIANO_MENU_SEL_W-1:0] menu_sel
);

    logic        start_seen;
    logic [22:0] strobes;

    // Everything but clear_note
    assign strobes = {store_note, clear_step, count_step, clear_note_count, count_note_count,
                      clear_lead, count_lead, clear_timer, count_timer, player_turn,
                      clear_beat, count_beat, leds_from_memory, leds_on, sound, won, lost,
                      capture_error, menu_open, capture_tempo, capture_key, capture_song,
                      menu_visible};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            start_seen <= 1'b0;
        end else if (start) begin
            start_seen <= 1'b1;
        end
    end

    assert property (@(posedge clock) disable iff (reset) !(won && lost))
        else $error("won and lost are high together");

    assert property (@(posedge clock) disable iff (reset) menu_sel[2] |-> menu_visible)
        else $error("error menu selected while the menu is hidden");

    // Error menu opens right after a loss
    assert property (@(posedge clock) disable iff (reset) lost |=> menu_open)
        else $error("menu_open did not follow lost");

    assert property (@(posedge clock) disable iff (reset) !start_seen |-> strobes == '0)
        else $error("strobe raised before start");

endmodule

`default_nettype wire

// ==== bench/piano_controller_tb.sv ====
// Testbench with LFSR stimulus, reference model, output checks and timeout
`default_nettype none

`include "piano_params.svh"

module piano_controller_tb;

    localparam int num_episodes   = 8;
    localparam int reset_cycles   = 5;
    localparam int episode_cycles = 3000;
    localparam int handed_cycles  = 400;
    // Eight full episodes plus a quarter margin
    localparam int cycle_limit = num_episodes * (episode_cycles + reset_cycles) * 5 / 4;

    localparam logic [5:0] m_idle = 6'h00, m_open = 6'h1C, m_mode = 6'h1D, m_tempo = 6'h1E,
                           m_key = 6'h1F, m_song = 6'h20, m_launch = 6'h30, m_handed = 6'h31;

    localparam logic [5:0] r_idle = 6'h3F, r_init = 6'h01, r_start = 6'h02, r_show = 6'h03,
                           r_show_wait = 6'h04, r_show_next = 6'h05, r_note_start = 6'h06,
                           r_note_wait = 6'h07, r_compare = 6'h09, r_won = 6'h0A,
                           r_next_note = 6'h0B, r_advance = 6'h13, r_note_wrong = 6'h14,
                           r_timing_wrong = 6'h15, r_note_play = 6'h17, r_show_last = 6'h18,
                           r_next_round = 6'h19, r_check_end = 6'h1A, r_store = 6'h1B,
                           r_err_open = 6'h21, r_err_menu = 6'h22, r_free_wait = 6'h23,
                           r_free_play = 6'h2D;

    logic clock = 1'b0;
    logic reset, start, enter;
    logic [`PIANO_MODE_W-1:0]  mode;
    logic [`PIANO_ERROR_W-1:0] error_choice;
    logic lead_done, step_done, note_made, note_right, timing_right;
    logic timing_low, at_round_end, timer_expired, song_end;
    logic clear_note, store_note, clear_step, count_step, clear_note_count, count_note_count;
    logic clear_lead, count_lead, clear_timer, count_timer, player_turn, clear_beat;
    logic count_beat, leds_from_memory, leds_on, sound, won, lost, capture_error;
    logic menu_open, capture_tempo, capture_key, capture_song, menu_visible;
    logic [`PIANO_MENU_SEL_W-1:0] menu_sel;
    logic [`PIANO_STATE_W-1:0]    db_state;

    logic [23:0] actual_strobes;
    logic [31:0] lfsr;
    logic [5:0]  model_menu;
    logic [5:0]  model_round;
    logic [1:0]  model_mode;
    int          episode;
    int          cycle_count = 0;

    piano_controller i_dut (.*);

    bind piano_controller piano_controller_props i_props (.*);

    assign actual_strobes = {clear_note, store_note, clear_step, count_step, clear_note_count,
                             count_note_count, clear_lead, count_lead, clear_timer,
                             count_timer, player_turn, clear_beat, count_beat,
                             leds_from_memory, leds_on, sound, won, lost, capture_error,
                             menu_open, capture_tempo, capture_key, capture_song,
                             menu_visible};

    initial begin
        forever #10 clock = ~clock;
    end

    // --------------------------------------------------
    // Random source
    // --------------------------------------------------

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] value);
        return {value[30:0], value[31] ^ value[21] ^ value[1] ^ value[0]};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] v;
        random_bits(1, v);
        start <= v[0];
        // Two high bits in a row
        random_bits(2, v);
        enter <= &v[1:0];
        random_bits(2, v);
        mode <= v[1:0];
        random_bits(3, v);
        error_choice <= v[2:0];
        random_bits(2, v);
        note_made <= &v[1:0];
        random_bits(8, v);
        {lead_done, step_done, note_right, timing_right, timing_low, at_round_end,
         timer_expired, song_end} <= v[7:0];
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    function automatic logic [5:0] menu_next(input logic [5:0] s);
        case (s)
            m_idle:  return start ? m_open : m_idle;
            m_open:  return m_mode;
            m_mode:  return enter ? m_tempo : m_mode;
            m_tempo: return enter ? m_key : m_tempo;
            m_key:   return !enter ? m_key : (model_mode[0] ? m_song : m_launch);
            m_song:  return enter ? m_launch : m_song;
            default: return m_handed;
        endcase
    endfunction

    function automatic logic [5:0] round_next(input logic [5:0] s);
        if (s == r_idle) begin
            return (model_menu == m_launch) ? r_init : r_idle;
        end
        // Freestyle loops between waiting and playing
        if (!model_mode[0]) begin
            return (s != r_init && note_made) ? r_free_play : r_free_wait;
        end
        case (s)
            r_init:       return r_start;
            r_start:      return lead_done ? r_show : r_start;
            r_show:       return r_show_wait;
            r_show_wait:  return !timing_low ? s : (at_round_end ? r_note_start : r_show_next);
            r_show_next:  return r_show;
            r_note_start: return r_note_wait;
            r_note_wait:  return timer_expired ? r_timing_wrong :
                                 (note_made ? r_note_play : s);
            r_note_play:  return note_made ? s : r_compare;
            r_compare:    return !note_right ? r_note_wrong :
                                 !timing_right ? r_timing_wrong :
                                 !at_round_end ? r_next_note :
                                 step_done ? r_won : r_advance;
            r_next_note:  return r_note_wait;
            r_advance:    return r_store;
            r_store:      return r_check_end;
            r_check_end:  return song_end ? r_won : r_next_round;
            r_next_round: return r_start;
            r_won:        return start ? r_init : r_won;
            r_note_wrong, r_timing_wrong: return r_err_open;
            r_err_open:   return r_err_menu;
            r_err_menu:   return !enter ? s :
                                 error_choice[2] ? r_start :
                                 error_choice[1] ? r_note_start :
                                 error_choice[0] ? r_show_last : s;
            r_show_last:  return timing_low ? r_note_wait : s;
            default:      return r_idle;
        endcase
    endfunction

    // Same bit order as actual_strobes
    function automatic logic [23:0] expected_strobes(input logic [5:0] m, input logic [5:0] r);
        logic wrong;
        wrong = r inside {r_note_wrong, r_timing_wrong};
        return {(m == m_idle) && (r == r_idle),
                r inside {r_note_play, r_free_play},
                r == r_init,
                r == r_next_round,
                r inside {r_note_start, r_start},
                r inside {r_advance, r_show_next, r_next_note},
                r inside {r_show, r_init, r_note_start},
                r == r_start,
                wrong || (r inside {r_next_note, r_note_start, r_init, r_check_end}),
                r == r_note_wait,
                r == r_note_wait,
                wrong || (r inside {r_show, r_note_wait, r_init, r_check_end}),
                r inside {r_show_last, r_show_wait, r_note_play, r_free_wait, r_free_play},
                r inside {r_show_wait, r_show_last},
                r inside {r_note_play, r_free_play, r_show_wait, r_show_last},
                r inside {r_note_play, r_free_play},
                r == r_won,
                wrong,
                r == r_compare,
                (m == m_open) || (r == r_err_open),
                m == m_tempo,
                m == m_key,
                m == m_song,
                (m inside {m_mode, m_tempo, m_key, m_song}) || (r == r_err_menu)};
    endfunction

    // One clock edge of model and stimulus, reset level for the next cycle
    task automatic step_cycle(input logic next_reset);
        logic [5:0] menu_new;
        logic [5:0] round_new;
        @(posedge clock);
        if (reset || next_reset) begin
            model_menu = m_idle;
            model_round = r_idle;
            model_mode = '0;
        end else begin
            menu_new = menu_next(model_menu);
            round_new = round_next(model_round);
            if (model_menu == m_mode && enter) begin
                model_mode = mode;
            end
            model_menu = menu_new;
            model_round = round_new;
        end
        reset <= next_reset;
        drive_inputs();
    endtask

    // --------------------------------------------------
    // Checks and timeout
    // --------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s episode %0d expected %h actual %h",
                     name, episode, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    always @(negedge clock) begin
        check_value("strobes", expected_strobes(model_menu, model_round), actual_strobes);
        check_value("menu_sel", {model_round == r_err_menu,
                                 model_menu inside {m_key, m_song},
                                 model_menu inside {m_tempo, m_song}}, menu_sel);
        check_value("db_state", (model_menu == m_handed) ? model_round : model_menu,
                    db_state);
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        int handed;
        lfsr = 32'h8e0c557d;
        reset = 1'b1;
        start = 1'b0;
        enter = 1'b0;
        mode = '0;
        error_choice = '0;
        {lead_done, step_done, note_made, note_right, timing_right} = '0;
        {timing_low, at_round_end, timer_expired, song_end} = '0;
        model_menu = m_idle;
        model_round = r_idle;
        model_mode = '0;
        for (episode = 0; episode < num_episodes; episode++) begin
            repeat (reset_cycles) step_cycle(1'b1);
            handed = 0;
            for (int n = 0; n < episode_cycles && handed < handed_cycles; n++) begin
                step_cycle(1'b0);
                if (model_menu == m_handed) begin
                    handed++;
                end
            end
        end
        // Let the last cycle be checked
        @(negedge clock);
        #1;
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/piano_pkg.sv
verilog/status_if.sv
verilog/menu_sequencer.sv
verilog/round_sequencer.sv
verilog/control_decoder.sv
verilog/piano_controller.sv
bench/piano_controller_props.sv
bench/piano_controller_tb.sv
